// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [corePkg::xlen-1:0] rd1,
    input  logic [corePkg::xlen-1:0] rd2,
    input  logic [corePkg::xlen-1:0] imm,
    input  logic                     aluSrcImm,
    input  isaPkg::aluOpT            aluOp,
    input  logic                     branch,
    output logic [corePkg::xlen-1:0] result,
    output logic                     takeBranch
);
    import isaPkg::*;
    import corePkg::*;

    logic [xlen-1:0] operandB;

    assign operandB = aluSrcImm ? imm : rd2; // Immediate or rs2

    always_comb begin
        case (aluOp)
            aluAdd:  result = rd1 + operandB;
            aluSub:  result = rd1 - operandB;
            aluAnd:  result = rd1 & operandB;
            aluOr:   result = rd1 | operandB;
            aluSlt:  result = {{(xlen-1){1'b0}}, $signed(rd1) < $signed(operandB)};
            default: result = '0;
        endcase
    end

    // beq taken when the subtraction is zero
    assign takeBranch = branch & (result == '0);

endmodule

// File: design/corePkg.sv
package corePkg;
    import isaPkg::*;

    // Datapath and storage sizes
    localparam int xlen      = 32;
    localparam int regAddrW  = 5;
    localparam int imemDepth = 256; // Words
    localparam int dmemDepth = 256; // Words
    localparam int imemAddrW = $clog2(imemDepth);
    localparam int dmemAddrW = $clog2(dmemDepth);

    localparam logic [xlen-1:0] pcResetValue = '0;

    // Decoded control for one instruction
    typedef struct packed {
        logic                regWrite;
        logic                aluSrcImm; // Operand B from imm
        logic                memWrite;
        logic                memToReg;  // Write back load data
        logic                branch;
        aluOpT               aluOp;
        logic [xlen-1:0]     imm;       // Sign extended, B-type pre-shifted
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rd;
    } ctrlT;

    // One committed instruction
    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     inst;
        logic                regWe;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     wdata;
        logic                memWe;
        logic [xlen-1:0]     memAddr;
        logic [xlen-1:0]     memData;
    } retireT;

endpackage

// File: design/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
    input  logic                     CLK,
    input  logic [corePkg::xlen-1:0] addr,
    input  logic                     we,
    input  logic [corePkg::xlen-1:0] wdata,
    output logic [corePkg::xlen-1:0] rdata
);
    import corePkg::*;

    logic [xlen-1:0]      mem [dmemDepth];
    logic [dmemAddrW-1:0] wordIdx;

    // Word aligned accesses only
    assign wordIdx = addr[dmemAddrW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wdata; // Store
        end
    end

    assign rdata = mem[wordIdx]; // Asynchronous read

endmodule

// File: design/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
    input  logic [corePkg::xlen-1:0] inst,
    output corePkg::ctrlT            ctrl
);
    import isaPkg::*;
    import corePkg::*;

    logic [opcodeW-1:0] opcode;
    logic [funct3W-1:0] funct3;
    logic [funct7W-1:0] funct7;
    logic [xlen-1:0]    immI;
    logic [xlen-1:0]    immS;
    logic [xlen-1:0]    immB;

    assign opcode = inst[opcodeLsb +: opcodeW];
    assign funct3 = inst[funct3Lsb +: funct3W];
    assign funct7 = inst[funct7Lsb +: funct7W];

    // Sign-extended immediates
    assign immI = {{(xlen-12){inst[signPos]}}, inst[immIPos +: 12]};
    assign immS = {{(xlen-12){inst[signPos]}}, inst[immSHiPos +: 7], inst[immSLoPos +: 5]};
    assign immB = {{(xlen-12){inst[signPos]}}, inst[immB11Pos], inst[immBMidPos +: 6],
                   inst[immBLoPos +: 4], 1'b0}; // Bit 0 always zero

    always_comb begin
        ctrl       = '0;  // No-op unless decoded below
        ctrl.rs1   = inst[rs1Lsb +: regAddrW];
        ctrl.rs2   = inst[rs2Lsb +: regAddrW];
        ctrl.rd    = inst[rdLsb +: regAddrW];
        ctrl.aluOp = aluAdd;

        case (opcode)
            opOp: begin
                ctrl.regWrite = 1'b1;
                // ALU control from funct7 and funct3
                case ({funct7, funct3})
                    {f7Base, f3AddSub}: ctrl.aluOp = aluAdd;
                    {f7Alt, f3AddSub}:  ctrl.aluOp = aluSub;
                    {f7Base, f3And}:    ctrl.aluOp = aluAnd;
                    {f7Base, f3Or}:     ctrl.aluOp = aluOr;
                    {f7Base, f3Slt}:    ctrl.aluOp = aluSlt;
                    default:            ctrl.regWrite = 1'b0; // Unsupported R-type
                endcase
            end
            opOpImm: begin
                ctrl.regWrite  = (funct3 == f3AddSub); // addi only
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immI;
            end
            opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1; // Base plus offset
                ctrl.memToReg  = 1'b1;
                ctrl.imm       = immI;
            end
            opStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immS;
            end
            opBranch: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub; // Equality via zero result
                ctrl.imm    = immB;
            end
            default: begin
                ctrl.regWrite = 1'b0; // Unknown opcode
            end
        endcase
    end

endmodule

// File: design/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic                     CLK,
    input  logic                     arstN,
    input  logic                     takeBranch,
    input  logic [corePkg::xlen-1:0] branchOffset,
    output logic [corePkg::xlen-1:0] pc,
    output logic [corePkg::xlen-1:0] inst
);
    import corePkg::*;

    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] branchTarget;
    logic [xlen-1:0] nextPc;

    // Instruction ROM
    logic [xlen-1:0] imem [imemDepth];

    initial begin
        $readmemh("program.hex", imem); // Program image
    end

    // Next address
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + branchOffset; // Offset already shifted
    assign nextPc       = takeBranch ? branchTarget : pcPlus4;

    // Program counter
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= pcResetValue;
        end else begin
            pc <= nextPc;
        end
    end

    // Word index, low two bits ignored
    assign inst = imem[pc[imemAddrW+1:2]];

endmodule

// File: design/isaPkg.sv
package isaPkg;

    // Field widths
    localparam int opcodeW = 7;
    localparam int funct3W = 3;
    localparam int funct7W = 7;

    // Major opcodes of the supported subset
    localparam logic [opcodeW-1:0] opOp     = 7'b0110011; // R-type ALU
    localparam logic [opcodeW-1:0] opOpImm  = 7'b0010011; // I-type ALU
    localparam logic [opcodeW-1:0] opLoad   = 7'b0000011;
    localparam logic [opcodeW-1:0] opStore  = 7'b0100011;
    localparam logic [opcodeW-1:0] opBranch = 7'b1100011;

    // funct3 codes
    localparam logic [funct3W-1:0] f3AddSub = 3'b000; // Also beq and addi
    localparam logic [funct3W-1:0] f3Slt    = 3'b010;
    localparam logic [funct3W-1:0] f3Or     = 3'b110;
    localparam logic [funct3W-1:0] f3And    = 3'b111;

    // funct7 codes
    localparam logic [funct7W-1:0] f7Base = 7'b0000000;
    localparam logic [funct7W-1:0] f7Alt  = 7'b0100000; // Selects sub

    // Register and funct field positions (lsb)
    localparam int opcodeLsb = 0;
    localparam int rdLsb     = 7;
    localparam int funct3Lsb = 12;
    localparam int rs1Lsb    = 15;
    localparam int rs2Lsb    = 20;
    localparam int funct7Lsb = 25;

    // Immediate slices
    localparam int immIPos    = 20; // imm[11:0]
    localparam int immSLoPos  = 7;  // imm[4:0] of S-type
    localparam int immSHiPos  = 25; // imm[11:5] of S-type
    localparam int immBLoPos  = 8;  // imm[4:1] of B-type
    localparam int immBMidPos = 25; // imm[10:5] of B-type
    localparam int immB11Pos  = 7;  // imm[11] of B-type
    localparam int signPos    = 31; // Sign bit of every immediate

    // ALU operations
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

endpackage

// File: design/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                         CLK,
    input  logic                         arstN,
    input  logic [corePkg::regAddrW-1:0] rs1,
    input  logic [corePkg::regAddrW-1:0] rs2,
    input  logic [corePkg::regAddrW-1:0] rd,
    input  logic                         we,
    input  logic [corePkg::xlen-1:0]     wdata,
    output logic [corePkg::xlen-1:0]     rd1,
    output logic [corePkg::xlen-1:0]     rd2
);
    import corePkg::*;

    // x1..x31 only, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Asynchronous reads
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: design/singleCpu.sv
`timescale 1ns/1ps

module singleCpu (
    input  logic            CLK,
    input  logic            arstN,
    output corePkg::retireT retire
);
    import corePkg::*;

    // Fetch
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;

    // Decode
    ctrlT ctrl;

    // Register file
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic            regWe;
    logic [xlen-1:0] wbData;

    // Execute and memory
    logic [xlen-1:0] aluResult;
    logic            takeBranch;
    logic            memWe;
    logic [xlen-1:0] rdData;

    fetchUnit fetch (
        .CLK          (CLK),
        .arstN        (arstN),
        .takeBranch   (takeBranch),
        .branchOffset (ctrl.imm),
        .pc           (pc),
        .inst         (inst)
    );

    decodeUnit decode (
        .inst (inst),
        .ctrl (ctrl)
    );

    registerFile regs (
        .CLK   (CLK),
        .arstN (arstN),
        .rs1   (ctrl.rs1),
        .rs2   (ctrl.rs2),
        .rd    (ctrl.rd),
        .we    (regWe),
        .wdata (wbData),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    alu execute (
        .rd1        (rd1),
        .rd2        (rd2),
        .imm        (ctrl.imm),
        .aluSrcImm  (ctrl.aluSrcImm),
        .aluOp      (ctrl.aluOp),
        .branch     (ctrl.branch),
        .result     (aluResult),
        .takeBranch (takeBranch)
    );

    dataMemory dmem (
        .CLK   (CLK),
        .addr  (aluResult),
        .we    (memWe),
        .wdata (rd2),
        .rdata (rdData)
    );

    // Write-back select
    assign wbData = ctrl.memToReg ? rdData : aluResult;

    // No commits while in reset, x0 writes dropped
    assign regWe = arstN & ctrl.regWrite & (ctrl.rd != '0);
    assign memWe = arstN & ctrl.memWrite;

    // Retire record of the instruction committing at the next edge
    always_comb begin
        retire         = '0;
        retire.valid   = arstN;
        retire.pc      = pc;
        retire.inst    = inst;
        retire.regWe   = regWe;
        retire.rd      = ctrl.rd;
        retire.wdata   = wbData;
        retire.memWe   = memWe;
        retire.memAddr = aluResult; // Byte address
        retire.memData = rd2;       // Store data
    end

endmodule

// File: program.hex
// One 32-bit instruction word per line in hex, loaded from byte address 0 upward
// Trailing text after the word is the assembly of that word
00500093 // 00: addi x1, x0, 5
FFD00113 // 04: addi x2, x0, -3
002081B3 // 08: add  x3, x1, x2
40208233 // 0c: sub  x4, x1, x2
0020F2B3 // 10: and  x5, x1, x2
0020E333 // 14: or   x6, x1, x2
001123B3 // 18: slt  x7, x2, x1
0020A433 // 1c: slt  x8, x1, x2
00402823 // 20: sw   x4, 16(x0)
01002483 // 24: lw   x9, 16(x0)
00700013 // 28: addi x0, x0, 7
00100533 // 2c: add  x10, x0, x1
0000850B // 30: unknown opcode
00208463 // 34: beq  x1, x2, +8 (not taken)
00A08663 // 38: beq  x1, x10, +12 (taken)
06300593 // 3c: addi x11, x0, 99
00000663 // 40: beq  x0, x0, +12
FE000CE3 // 44: beq  x0, x0, -8
00100793 // 48: addi x15, x0, 1 (skipped)
80000693 // 4c: addi x13, x0, -2048
00D02A23 // 50: sw   x13, 20(x0)
01402703 // 54: lw   x14, 20(x0)
00000063 // 58: beq  x0, x0, 0 (self-loop)

// File: run.sh
#!/usr/bin/env bash
# Build and run the single-cycle core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module singleCpuTb -f sim.f -o singleCpuSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/singleCpuSim
simStatus=$?
if [ $simStatus -ne 0 ]; then
    echo "Simulation failed with status $simStatus"
    exit $simStatus
fi

echo "Simulation finished cleanly"
exit 0

// File: sim.f
design/isaPkg.sv
design/corePkg.sv
design/fetchUnit.sv
design/registerFile.sv
design/decodeUnit.sv
design/alu.sv
design/dataMemory.sv
design/singleCpu.sv
verification/singleCpuProperties.sv
verification/singleCpuTb.sv

// File: verification/singleCpuProperties.sv
`timescale 1ns/1ps

module singleCpuProperties (
    input logic            CLK,
    input logic            arstN,
    input corePkg::retireT retire,
    input logic            takeBranch
);
    import corePkg::*;

    // Nothing retires while reset is held, and the PC sits at its reset value
    validLowInReset: assert property (
        @(posedge CLK) !arstN |-> (!retire.valid && retire.pc == pcResetValue)
    ) else $error("retire.valid high or pc away from its reset value during reset");

    // Sequential flow moves the PC by one word
    pcStep: assert property (
        @(posedge CLK) disable iff (!arstN)
        (retire.valid && !takeBranch) |=> (retire.pc == $past(retire.pc) + 32'd4)
    ) else $error("pc did not advance by 4 without a taken branch");

    // x0 writes never show up as commits
    noX0Write: assert property (@(posedge CLK) retire.regWe |-> (retire.rd != 5'd0))
        else $error("regWe set with rd equal to 0");

endmodule

bind singleCpu singleCpuProperties props (
    .CLK        (CLK),
    .arstN      (arstN),
    .retire     (retire),
    .takeBranch (takeBranch)
);

// File: verification/singleCpuTb.sv
`timescale 1ns/1ps

module singleCpuTb;
    import isaPkg::*;
    import corePkg::*;

    logic   CLK;
    logic   arstN;
    retireT retire;

    // ISA model state
    logic [xlen-1:0] progMem [imemDepth];
    logic [xlen-1:0] modelRegs [32];
    logic [xlen-1:0] modelMem [dmemDepth];
    logic [xlen-1:0] modelPc;
    logic            programDone; // Model reached the self-loop
    int unsigned     seedSink;

    singleCpu i_dut (
        .CLK    (CLK),
        .arstN  (arstN),
        .retire (retire)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK; // 100 ns period
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %h actual %h", testName, expected, actual);
            $display("Some tests failed");
            $fatal(1, "retire record mismatch");
        end
    endtask

    task automatic initModel();
        $readmemh("program.hex", progMem); // Same image as the core
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0; // Register file clears on reset
        end
        for (int i = 0; i < dmemDepth; i++) begin
            modelMem[i] = '0;
        end
        modelPc = '0; // Reset vector
    endtask

    // Steps the ISA model by one instruction
    // Returns the record the core must retire for it
    function automatic retireT modelStep();
        retireT      want;
        logic [31:0] inst;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] addr;
        logic [31:0] result;
        logic        writeRd;
        logic [31:0] nextPc;

        inst   = progMem[modelPc[9:2]];
        opcode = inst[6:0];
        rd     = inst[11:7];
        funct3 = inst[14:12];
        funct7 = inst[31:25];
        a      = modelRegs[inst[19:15]]; // rs1
        b      = modelRegs[inst[24:20]]; // rs2
        immI   = {{20{inst[31]}}, inst[31:20]};
        immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immB   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

        addr      = '0;
        result    = '0;
        writeRd   = 1'b0;
        nextPc    = modelPc + 32'd4;
        want      = '0;
        want.valid = 1'b1;
        want.pc    = modelPc;
        want.inst  = inst;
        want.rd    = rd;

        case (opcode)
            opOp: begin
                writeRd = 1'b1;
                case ({funct7, funct3})
                    {f7Base, f3AddSub}: result = a + b;
                    {f7Alt, f3AddSub}:  result = a - b;
                    {f7Base, f3And}:    result = a & b;
                    {f7Base, f3Or}:     result = a | b;
                    {f7Base, f3Slt}:    result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:            writeRd = 1'b0; // Not a supported R-type
                endcase
            end
            opOpImm: begin
                writeRd = (funct3 == f3AddSub); // addi
                result  = a + immI;
            end
            opLoad: begin
                addr    = a + immI;
                writeRd = 1'b1;
                result  = modelMem[addr[9:2]]; // Word lw
            end
            opStore: begin
                addr             = a + immS;
                want.memWe       = 1'b1;
                want.memAddr     = addr;
                want.memData     = b;
                modelMem[addr[9:2]] = b;
            end
            opBranch: begin
                if (a == b) begin
                    nextPc = modelPc + immB; // beq taken
                end
            end
            default: result = '0; // Unknown opcode acts as a no-op
        endcase

        // x0 stays zero
        if (writeRd && rd != 5'd0) begin
            want.regWe    = 1'b1;
            want.wdata    = result;
            modelRegs[rd] = result;
        end

        modelPc = nextPc;
        return want;
    endfunction

    // Retire is sampled at the edge that commits it
    always @(posedge CLK) begin : compareRetire
        retireT want;
        string  where;

        if (!arstN) begin
            checkValue("reset valid", 32'd0, 32'(retire.valid));
            checkValue("reset pc", 32'h0, retire.pc);
            checkValue("reset regWe", 32'd0, 32'(retire.regWe));
            checkValue("reset memWe", 32'd0, 32'(retire.memWe));
        end else if (!programDone) begin
            want  = modelStep();
            where = $sformatf("retire at pc %h", want.pc);
            checkValue({where, " valid"}, 32'd1, 32'(retire.valid));
            checkValue({where, " pc"}, want.pc, retire.pc);
            checkValue({where, " inst"}, want.inst, retire.inst);
            checkValue({where, " regWe"}, 32'(want.regWe), 32'(retire.regWe));
            checkValue({where, " memWe"}, 32'(want.memWe), 32'(retire.memWe));
            if (want.regWe) begin
                checkValue({where, " rd"}, 32'(want.rd), 32'(retire.rd));
                checkValue({where, " wdata"}, want.wdata, retire.wdata);
            end
            if (want.memWe) begin
                checkValue({where, " memAddr"}, want.memAddr, retire.memAddr);
                checkValue({where, " memData"}, want.memData, retire.memData);
            end
            // PC repeats only at the closing self-loop
            if (modelPc == want.pc) begin
                programDone = 1'b1;
            end
        end
    end

    initial begin : mainFlow
        int waitCycles;

        seedSink    = $urandom(32'h9ad6); // Seed the generator once
        arstN       = 1'b0;
        programDone = 1'b0;
        initModel();

        repeat (10) @(posedge CLK); // Reset held 10 cycles
        arstN <= 1'b1;

        // Bounded wait for the self-loop
        waitCycles = 0;
        while (!programDone && waitCycles < 200) begin
            @(negedge CLK);
            waitCycles++;
        end

        if (programDone) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Timeout, the program did not reach its final loop in 200 cycles");
            $display("Some tests failed");
            $fatal(1, "program did not reach its final loop");
        end
    end

endmodule
